// File: include/cpu4_config.svh
`ifndef CPU4_CONFIG_SVH
`define CPU4_CONFIG_SVH

`define CPU4_PC_RESET    12'h100
`define CPU4_SP_RESET    8'hF0

// opcode bases and the masks that select their fixed bits.
`define CPU4_OP_LD_R_I   12'hE00
`define CPU4_MASK_LD_R_I 12'hFC0
`define CPU4_OP_LD_X_E   12'hB00
`define CPU4_OP_LD_Y_E   12'h800
`define CPU4_MASK_LD_E   12'hF00

`define CPU4_OP_PUSH     12'hFC0
`define CPU4_OP_POP      12'hFD0
`define CPU4_MASK_STACK  12'hFF0
`define CPU4_SRC_LAST    4'hA     // F is the last stack source.

`define CPU4_OP_NOP      12'hFFB

`endif

// File: hw/cpu4_pkg.sv
package cpu4_pkg;

  typedef logic [3:0]  nibble_t;
  typedef logic [11:0] opcode_t;
  typedef logic [11:0] addr_t;
  typedef logic [7:0]  sp_t;   // stack lives in page 0.
  typedef logic [7:0]  imm_t;

  // same bit order as the F nibble.
  typedef struct packed {
    logic interrupt;
    logic decimal;
    logic zero;
    logic carry;
  } flags_t;

  typedef enum logic [2:0] {
    OP_NOP,
    OP_LD_R_I,
    OP_LD_X_E,
    OP_LD_Y_E,
    OP_PUSH,
    OP_POP
  } op_e;

  // values equal the low nibble of the PUSH and POP opcodes.
  typedef enum logic [3:0] {
    SRC_A  = 4'h0,
    SRC_B  = 4'h1,
    SRC_MX = 4'h2,
    SRC_MY = 4'h3,
    SRC_XP = 4'h4,
    SRC_XH = 4'h5,
    SRC_XL = 4'h6,
    SRC_YP = 4'h7,
    SRC_YH = 4'h8,
    SRC_YL = 4'h9,
    SRC_F  = 4'hA
  } src_e;

  typedef enum logic [2:0] {
    ST_FETCH,
    ST_DECODE,
    ST_READ,
    ST_WRITE,
    ST_RETIRE
  } ctrl_state_e;

  typedef struct packed {
    logic  cyc;
    logic  stb;
    addr_t adr;
  } ibus_req_t;

  typedef struct packed {
    logic    ack;
    opcode_t dat;
  } ibus_rsp_t;

  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    addr_t   adr;
    nibble_t dat;
  } dbus_req_t;

  typedef struct packed {
    logic    ack;
    nibble_t dat;
  } dbus_rsp_t;

  // pair writes dat_hi:dat into the low byte of X or Y.
  typedef struct packed {
    logic    en;
    logic    pair;
    src_e    tgt;
    nibble_t dat_hi;
    nibble_t dat;
    logic    sp_inc;
    logic    sp_dec;
  } reg_wr_t;

  typedef struct packed {
    nibble_t a;
    nibble_t b;
    addr_t   x;
    addr_t   y;
    sp_t     sp;
    addr_t   pc;
    flags_t  flags;
  } cpu_regs_t;

endpackage

// File: hw/cpu4_regs.sv
`timescale 1ns/1ps
`include "cpu4_config.svh"

module cpu4_regs
  import cpu4_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  reg_wr_t   wr,
  input  logic      pc_inc,
  output cpu_regs_t state
);

  nibble_t a;
  nibble_t b;
  addr_t   x;
  addr_t   y;
  sp_t     sp;
  addr_t   pc;
  flags_t  flags;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a     <= '0;
      b     <= '0;
      x     <= '0;
      y     <= '0;
      sp    <= `CPU4_SP_RESET;
      pc    <= `CPU4_PC_RESET;
      flags <= '0;
    end else begin
      if (pc_inc) begin
        pc <= pc + 12'd1;
      end

      if (wr.sp_inc) begin
        sp <= sp + 8'd1;
      end else if (wr.sp_dec) begin
        sp <= sp - 8'd1;
      end

      if (wr.en) begin
        case (wr.tgt)
          SRC_A:  a <= wr.dat;
          SRC_B:  b <= wr.dat;
          SRC_XP: x[11:8] <= wr.dat;
          SRC_XH: x[7:4] <= wr.dat;
          SRC_XL: begin
            x[3:0] <= wr.dat;
            if (wr.pair) begin
              x[7:4] <= wr.dat_hi; // LD X,e.
            end
          end
          SRC_YP: y[11:8] <= wr.dat;
          SRC_YH: y[7:4] <= wr.dat;
          SRC_YL: begin
            y[3:0] <= wr.dat;
            if (wr.pair) begin
              y[7:4] <= wr.dat_hi;
            end
          end
          SRC_F:  flags <= flags_t'(wr.dat);
          default: begin
            // MX and MY live in RAM, not here.
          end
        endcase
      end
    end
  end

  assign state = '{
    a:     a,
    b:     b,
    x:     x,
    y:     y,
    sp:    sp,
    pc:    pc,
    flags: flags
  };

  // control never moves SP both ways in one instruction.
  a_sp_one_way: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(wr.sp_inc && wr.sp_dec)
  );

  // byte loads only land on the low byte of X or Y.
  a_pair_target: assert property (
    @(posedge clk) disable iff (!rst_n)
    (wr.en && wr.pair) |-> (wr.tgt inside {SRC_XL, SRC_YL})
  );

endmodule

// File: hw/cpu4_decoder.sv
`timescale 1ns/1ps
`include "cpu4_config.svh"

module cpu4_decoder
  import cpu4_pkg::*;
(
  input  opcode_t opcode,
  output op_e     op,
  output src_e    src,
  output imm_t    imm
);

  logic is_ld_r_i;
  logic is_ld_x_e;
  logic is_ld_y_e;
  logic is_push;
  logic is_pop;
  logic stack_src_ok;

  // E00-E3F, r in [5:4], i in [3:0].
  assign is_ld_r_i = (opcode & `CPU4_MASK_LD_R_I) == `CPU4_OP_LD_R_I;

  // B00-BFF and 800-8FF carry the byte in [7:0].
  assign is_ld_x_e = (opcode & `CPU4_MASK_LD_E) == `CPU4_OP_LD_X_E;
  assign is_ld_y_e = (opcode & `CPU4_MASK_LD_E) == `CPU4_OP_LD_Y_E;

  // FCB-FCF and FDB-FDF fall through to NOP.
  assign stack_src_ok = opcode[3:0] <= `CPU4_SRC_LAST;
  assign is_push = ((opcode & `CPU4_MASK_STACK) == `CPU4_OP_PUSH) && stack_src_ok;
  assign is_pop  = ((opcode & `CPU4_MASK_STACK) == `CPU4_OP_POP) && stack_src_ok;

  always_comb begin
    op  = OP_NOP;
    src = SRC_A;
    imm = '0;

    if (is_ld_r_i) begin
      op  = OP_LD_R_I;
      src = src_e'({2'b00, opcode[5:4]}); // A, B, MX, MY.
      imm = {4'h0, opcode[3:0]};
    end else if (is_ld_x_e) begin
      op  = OP_LD_X_E;
      src = SRC_XL;
      imm = opcode[7:0];
    end else if (is_ld_y_e) begin
      op  = OP_LD_Y_E;
      src = SRC_YL;
      imm = opcode[7:0];
    end else if (is_push) begin
      op  = OP_PUSH;
      src = src_e'(opcode[3:0]);
    end else if (is_pop) begin
      op  = OP_POP;
      src = src_e'(opcode[3:0]);
    end
  end

endmodule

// File: hw/cpu4_control.sv
`timescale 1ns/1ps

module cpu4_control
  import cpu4_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  op_e       op,
  input  src_e      src,
  input  imm_t      imm,
  input  cpu_regs_t regs,
  output opcode_t   opcode,
  output ibus_req_t ibus,
  input  ibus_rsp_t ibus_rsp,
  output dbus_req_t dbus,
  input  dbus_rsp_t dbus_rsp,
  output reg_wr_t   wr,
  output logic      pc_inc
);

  ctrl_state_e state;
  ctrl_state_e state_nxt;

  logic    ib_cyc;
  addr_t   ib_adr;
  nibble_t rd_q;      // nibble carried from READ to WRITE or RETIRE.
  logic    src_mem;
  logic    wr_bus;
  addr_t   mem_adr;
  addr_t   stack_adr;
  sp_t     push_sp;
  nibble_t src_val;

  assign src_mem   = (src == SRC_MX) || (src == SRC_MY);
  assign mem_adr   = (src == SRC_MY) ? regs.y : regs.x;
  assign stack_adr = {4'h0, regs.sp};
  assign push_sp   = regs.sp - 8'd1; // SP itself moves at retire.

  // pop into a register spends WRITE without a bus cycle.
  assign wr_bus = (op != OP_POP) || src_mem;

  always_comb begin
    case (src)
      SRC_A:   src_val = regs.a;
      SRC_B:   src_val = regs.b;
      SRC_XP:  src_val = regs.x[11:8];
      SRC_XH:  src_val = regs.x[7:4];
      SRC_XL:  src_val = regs.x[3:0];
      SRC_YP:  src_val = regs.y[11:8];
      SRC_YH:  src_val = regs.y[7:4];
      SRC_YL:  src_val = regs.y[3:0];
      SRC_F:   src_val = nibble_t'(regs.flags);
      default: src_val = rd_q; // MX and MY come back from RAM.
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_FETCH;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      ST_FETCH: begin
        if (ib_cyc && ibus_rsp.ack) begin
          state_nxt = ST_DECODE;
        end
      end
      ST_DECODE: begin
        case (op)
          OP_PUSH:   state_nxt = src_mem ? ST_READ : ST_WRITE;
          OP_POP:    state_nxt = ST_READ;
          OP_LD_R_I: state_nxt = src_mem ? ST_WRITE : ST_RETIRE;
          default:   state_nxt = ST_RETIRE;
        endcase
      end
      ST_READ: begin
        if (dbus_rsp.ack) begin
          state_nxt = ST_WRITE;
        end
      end
      ST_WRITE: begin
        if (!wr_bus || dbus_rsp.ack) begin
          state_nxt = ST_RETIRE;
        end
      end
      default: state_nxt = ST_FETCH;
    endcase
  end

  // first FETCH cycle picks up the PC that advanced at retire.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ib_cyc <= 1'b0;
    end else if (state == ST_FETCH) begin
      if (!ib_cyc) begin
        ib_cyc <= 1'b1;
      end else if (ibus_rsp.ack) begin
        ib_cyc <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_FETCH && !ib_cyc) begin
      ib_adr <= regs.pc;
    end
    if (ib_cyc && ibus_rsp.ack) begin
      opcode <= ibus_rsp.dat;
    end
    if (state == ST_READ && dbus_rsp.ack) begin
      rd_q <= dbus_rsp.dat;
    end
  end

  assign ibus = '{cyc: ib_cyc, stb: ib_cyc, adr: ib_adr};

  always_comb begin
    dbus = '0;
    if (state == ST_READ) begin
      dbus.cyc = 1'b1;
      dbus.stb = 1'b1;
      dbus.adr = (op == OP_POP) ? stack_adr : mem_adr;
    end else if (state == ST_WRITE && wr_bus) begin
      dbus.cyc = 1'b1;
      dbus.stb = 1'b1;
      dbus.we  = 1'b1;
      dbus.adr = (op == OP_PUSH) ? {4'h0, push_sp} : mem_adr;
      if (op == OP_LD_R_I) begin
        dbus.dat = imm[3:0];
      end else if (op == OP_PUSH) begin
        dbus.dat = src_val;
      end else begin
        dbus.dat = rd_q;
      end
    end
  end

  // one command per instruction, all at retire.
  always_comb begin
    wr = '0;
    if (state == ST_RETIRE) begin
      case (op)
        OP_LD_R_I: begin
          wr.en  = !src_mem;
          wr.tgt = src;
          wr.dat = imm[3:0];
        end
        OP_LD_X_E, OP_LD_Y_E: begin
          wr.en     = 1'b1;
          wr.pair   = 1'b1;
          wr.tgt    = src;
          wr.dat    = imm[3:0];
          wr.dat_hi = imm[7:4];
        end
        OP_PUSH: wr.sp_dec = 1'b1;
        OP_POP: begin
          wr.en     = !src_mem;
          wr.tgt    = src;
          wr.dat    = rd_q;
          wr.sp_inc = 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

  assign pc_inc = (state == ST_RETIRE);

  a_stb_cyc: assert property (
    @(posedge clk) disable iff (!rst_n)
    (!ibus.stb || ibus.cyc) && (!dbus.stb || dbus.cyc)
  );

  a_ibus_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (ibus.stb && !ibus_rsp.ack) |=> $stable(ibus)
  );

  a_dbus_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (dbus.stb && !dbus_rsp.ack) |=> $stable(dbus)
  );

  // a read keeps we low through its ack.
  a_read_no_we: assert property (
    @(posedge clk) disable iff (!rst_n)
    ($rose(dbus.stb) && !dbus.we) |-> (!dbus.we until_with dbus_rsp.ack)
  );

endmodule

// File: hw/cpu4_top.sv
`timescale 1ns/1ps

module cpu4_top
  import cpu4_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  output ibus_req_t ibus,
  input  ibus_rsp_t ibus_rsp,
  output dbus_req_t dbus,
  input  dbus_rsp_t dbus_rsp
);

  cpu_regs_t regs;
  reg_wr_t   wr;
  logic      pc_inc;
  opcode_t   opcode;
  op_e       op;
  src_e      src;
  imm_t      imm;

  cpu4_regs i_cpu4_regs (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr     (wr),
    .pc_inc (pc_inc),
    .state  (regs)
  );

  cpu4_decoder i_cpu4_decoder (
    .opcode (opcode),
    .op     (op),
    .src    (src),
    .imm    (imm)
  );

  cpu4_control i_cpu4_control (
    .clk      (clk),
    .rst_n    (rst_n),
    .op       (op),
    .src      (src),
    .imm      (imm),
    .regs     (regs),
    .opcode   (opcode),
    .ibus     (ibus),
    .ibus_rsp (ibus_rsp),
    .dbus     (dbus),
    .dbus_rsp (dbus_rsp),
    .wr       (wr),
    .pc_inc   (pc_inc)
  );

endmodule

// File: tests/cpu4_tb.sv
`timescale 1ns/1ps
`include "cpu4_config.svh"

module cpu4_tb
  import cpu4_pkg::*;
();

  logic      clk;
  logic      rst_n;
  ibus_req_t ibus;
  ibus_rsp_t ibus_rsp;
  dbus_req_t dbus;
  dbus_rsp_t dbus_rsp;

  opcode_t     prog [4096];
  nibble_t     ram [4096];
  addr_t       w_adr [$];   // expected data writes, in order.
  nibble_t     w_dat [$];
  int          n_instr;
  int          w_idx;
  int          fetch_count;
  addr_t       exp_pc;
  logic        stim_ready;
  logic [31:0] lfsr_state;

  logic ib_busy;
  logic db_busy;
  int   ib_wait;
  int   db_wait;

  cpu4_top i_cpu4_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .ibus     (ibus),
    .ibus_rsp (ibus_rsp),
    .dbus     (dbus),
    .dbus_rsp (dbus_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic end_with_failure();
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped.");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL at %0t: %s = %0h, expected %0h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  // galois form of x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic draw_wait(output int w);
    w = 0;
    repeat (2) begin
      w = (w << 1) | lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic load_stim();
    int            fd;
    int            rc;
    logic [63:0]   tag;
    logic [1023:0] rest;
    logic [11:0]   adr;
    logic [11:0]   val;
    for (int i = 0; i < 4096; i++) begin
      prog[i] = {1'b0, i[10:0] ^ {i[11], 10'b0}}; // top bit clear, so a NOP.
      ram[i]  = i[11:8] ^ i[7:4] ^ i[3:0] ^ 4'h5;
    end
    fd = $fopen("tests/cpu4_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open tests/cpu4_stim.txt");
      end_with_failure();
    end
    while ($fscanf(fd, "%s", tag) == 1) begin
      if (tag == "#") begin
        rc = $fgets(rest, fd); // rest of a comment.
      end else if (tag == "E") begin
        rc = $fscanf(fd, "%d", n_instr);
      end else begin
        rc = $fscanf(fd, "%h %h", adr, val);
        if (rc != 2) begin
          $display("stim record %s is missing its fields", tag);
          end_with_failure();
        end
        if (tag == "P") begin
          prog[adr] = val;
        end else if (tag == "M") begin
          ram[adr] = val[3:0];
        end else if (tag == "W") begin
          w_adr.push_back(adr);
          w_dat.push_back(val[3:0]);
        end else begin
          $display("unknown record %s in the stim file", tag);
          end_with_failure();
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic match_write(input addr_t adr, input nibble_t dat);
    if (w_idx >= w_adr.size()) begin
      $display("unexpected data write of %h at %h after the last expected write", dat, adr);
      end_with_failure();
    end
    check_value("dbus.adr", adr, w_adr[w_idx]);
    check_value("dbus.dat", dat, w_dat[w_idx]);
    w_idx++;
  endtask

  task automatic answer_fetch();
    if (ibus.cyc && ibus.stb) begin
      if (!ib_busy) begin
        ib_busy = 1'b1;
        draw_wait(ib_wait);
        check_value("ibus.adr", ibus.adr, exp_pc);
        exp_pc = exp_pc + 12'd1;
        fetch_count++;
      end
      if (ib_wait == 0) begin
        ibus_rsp.ack = 1'b1;
        ibus_rsp.dat = prog[ibus.adr];
        ib_busy = 1'b0;
      end else begin
        ibus_rsp.ack = 1'b0;
        ib_wait--;
      end
    end else begin
      ibus_rsp = '0;
      ib_busy = 1'b0;
    end
  endtask

  task automatic answer_data();
    if (dbus.cyc && dbus.stb) begin
      if (!db_busy) begin
        db_busy = 1'b1;
        draw_wait(db_wait);
      end
      if (db_wait == 0) begin
        dbus_rsp.ack = 1'b1;
        db_busy = 1'b0;
        if (dbus.we) begin
          match_write(dbus.adr, dbus.dat);
          ram[dbus.adr] = dbus.dat;
          dbus_rsp.dat = '0;
        end else begin
          dbus_rsp.dat = ram[dbus.adr];
        end
      end else begin
        dbus_rsp.ack = 1'b0;
        db_wait--;
      end
    end else begin
      dbus_rsp = '0;
      db_busy = 1'b0;
    end
  endtask

  // both slaves in one process keeps the lfsr draws in a fixed order.
  initial begin
    ibus_rsp    = '0;
    dbus_rsp    = '0;
    ib_busy     = 1'b0;
    db_busy     = 1'b0;
    ib_wait     = 0;
    db_wait     = 0;
    fetch_count = 0;
    w_idx       = 0;
    exp_pc      = `CPU4_PC_RESET;
    forever begin
      @(posedge clk);
      #1;
      answer_fetch();
      answer_data();
    end
  end

  initial begin : watchdog
    int unsigned limit;
    wait (stim_ready);
    limit = n_instr * 6 * 4 + 8 + 200;
    repeat (limit) @(posedge clk);
    $display("timeout: the program did not finish within %0d cycles", limit);
    end_with_failure();
  end

  initial begin
    rst_n      = 1'b0;
    stim_ready = 1'b0;
    lfsr_state = 32'd72956;
    n_instr    = 0;
    load_stim();
    stim_ready = 1'b1;
    repeat (8) begin
      @(posedge clk);
      #1;
      check_value("ibus.cyc", ibus.cyc, 1'b0);
      check_value("dbus.cyc", dbus.cyc, 1'b0);
    end
    rst_n = 1'b1;
    // next fetch starting means the last instruction retired.
    wait (fetch_count > n_instr);
    @(posedge clk);
    #1;
    if (w_idx != w_adr.size()) begin
      $display("only %0d of %0d expected data writes were seen", w_idx, w_adr.size());
      end_with_failure();
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

// File: tests/cpu4_stim.txt
# P addr word and M addr nibble preload program and RAM. W addr nibble is an expected write.
# E count is the number of program instructions. all fields are hex except the count.
E 39
M 03A 9
M 0C7 6
P 100 E05 # LD A,5
P 101 E1C # LD B,C
P 102 B3A # LD X,3A
P 103 8C7 # LD Y,C7
P 104 FCA # PUSH F
P 105 FC0
P 106 FC1
P 107 FC4
P 108 FC5
P 109 FC6
P 10A FC7
P 10B FC8
P 10C FC9
P 10D FC2 # PUSH MX
P 10E FC3 # PUSH MY
P 10F E24 # LD MX,4
P 110 FCB # undefined, runs as NOP
P 111 FD7 # POP YP
P 112 FD4
P 113 FD0
P 114 FD6
P 115 FD1
P 116 FD8
P 117 FDA
P 118 FD9
P 119 FD5
P 11A FD3 # POP MY
P 11B FD2 # POP MX
P 11C FC2 # pushes in reverse order
P 11D FC3
P 11E FC5
P 11F FC9
P 120 FCA
P 121 FC8
P 122 FC1
P 123 FC6
P 124 FC0
P 125 FC4
P 126 FC7
W 0EF 0
W 0EE 5
W 0ED C
W 0EC 0
W 0EB 3
W 0EA A
W 0E9 0
W 0E8 C
W 0E7 7
W 0E6 9
W 0E5 6
W 03A 4
W 6A0 5
W 9CC 0
W 0EF 0
W 0EE 5
W 0ED C
W 0EC 0
W 0EB 3
W 0EA A
W 0E9 0
W 0E8 C
W 0E7 7
W 0E6 9
W 0E5 6

// File: sources.f
+incdir+include
hw/cpu4_pkg.sv
hw/cpu4_regs.sv
hw/cpu4_decoder.sv
hw/cpu4_control.sv
hw/cpu4_top.sv
tests/cpu4_tb.sv

// File: Bender.yml
package:
  name: cpu4

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/cpu4_pkg.sv
      - hw/cpu4_regs.sv
      - hw/cpu4_decoder.sv
      - hw/cpu4_control.sv
      - hw/cpu4_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/cpu4_tb.sv
